// File: dv/inst_decode_stage_chk.sv
`timescale 1ns/1ns

module inst_decode_stage_chk (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     in_valid,
    input logic                     out_valid,
    input decode_pkg::decode_ctrl_t ctrl,
    input decode_pkg::excp_t        excp
);
    import decode_pkg::*;

    // no valid output while held in reset
    a_valid_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (!arst_n)
        ##1 out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by one cycle");

    // an unknown word must not start any datapath work
    a_ine_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        excp.ine |-> (ctrl.alu_op == ALU_NONE && ctrl.mem_op == MEM_NONE))
        else $error("ine raised with an active alu or memory op");

endmodule

bind inst_decode_stage inst_decode_stage_chk u_chk (.*);

// File: dv/inst_decode_stage_tb.sv
`timescale 1ns/1ns

module inst_decode_stage_tb;
    import decode_pkg::*;

    // immediate formats
    localparam logic [2:0] I_NO = 3'd0, I_U5 = 3'd1, I_S12 = 3'd2, I_U12 = 3'd3;
    localparam logic [2:0] I_B16 = 3'd4, I_U20 = 3'd5, I_P20 = 3'd6, I_J26 = 3'd7;

    typedef struct packed {
        logic [31:0] tmpl;
        logic [2:0]  rmask;
        logic [3:0]  side;
        alu_op_e     alu;
        md_op_e      md;
        logic        sgn;
        br_op_e      br;
        mem_op_e     mem;
        csr_op_e     csr;
        logic [6:0]  flags;
        logic [2:0]  fmt;
        excp_t       ex;
    } entry_t;

    logic         clk;
    logic         arst_n;
    logic         in_valid;
    logic [31:0]  inst;
    logic [1:0]   csr_plv;
    logic         csr_has_int;
    logic         excp_adef;
    logic         out_valid;
    decode_ctrl_t ctrl;
    logic [31:0]  imm;
    excp_t        excp;

    entry_t       tbl[$];
    logic [2:0]   cur_mask;
    logic [3:0]   cur_side;
    logic [31:0]  lcg_state;
    int           ctrl_errs;
    int           imm_errs;
    int           excp_errs;
    int           valid_errs;

    inst_decode_stage DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] expect_imm(input logic [2:0] fmt, input logic [31:0] w);
        case (fmt)
            I_U5:    return {27'b0, w[14:10]};
            I_S12:   return {{20{w[21]}}, w[21:10]};
            I_U12:   return {20'b0, w[21:10]};
            I_B16:   return {{14{w[25]}}, w[25:10], 2'b0};
            I_U20:   return {w[24:5], 12'b0};
            I_P20:   return {{10{w[24]}}, w[24:5], 2'b0};
            I_J26:   return {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
            default: return 32'b0;
        endcase
    endfunction

    task automatic row(input logic [31:0] t, input alu_op_e a, input md_op_e m, input logic s,
                       input br_op_e b, input mem_op_e me, input csr_op_e c,
                       input logic [6:0] f, input logic [2:0] fm, input logic [6:0] ex);
        entry_t e;
        e = '{t, cur_mask, cur_side, a, m, s, b, me, c, f, fm, excp_t'(ex)};
        tbl.push_back(e);
    endtask

    task automatic check_ctrl(input decode_ctrl_t got, input decode_ctrl_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t ctrl got=%h exp=%h", $time, got, exp);
            ctrl_errs++;
        end
    endtask

    task automatic check_imm(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t imm got=%h exp=%h", $time, got, exp);
            imm_errs++;
        end
    endtask

    task automatic check_excp(input excp_t got, input excp_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t excp got=%b exp=%b", $time, got, exp);
            excp_errs++;
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t out_valid got=%b exp=%b", $time, got, exp);
            valid_errs++;
        end
    endtask

    // runaway guard for the whole run
    initial begin
        #100000;
        $display("timeout: the test sequence did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        entry_t       e;
        decode_ctrl_t exp_ctrl;
        logic [31:0]  exp_imm;
        logic [31:0]  w;
        logic [31:0]  r;

        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b1;
        inst = 32'h02bf0000;
        csr_plv = 2'd3;
        csr_has_int = 1'b1;
        excp_adef = 1'b1;
        lcg_state = 32'd7211;
        ctrl_errs = 0;
        imm_errs = 0;
        excp_errs = 0;
        valid_errs = 0;
        cur_mask = 3'b111;
        cur_side = 4'h0;

        row(32'h00100000, ALU_ADD, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00110000, ALU_SUB, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00120000, ALU_SLT, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00128000, ALU_SLTU, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00140000, ALU_NOR, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00148000, ALU_AND, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00158000, ALU_XOR, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00178000, ALU_SRL, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00180000, ALU_SRA, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00408000, ALU_SLL, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_U5, 7'h00);
        row(32'h00448000, ALU_SRL, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_U5, 7'h00);
        row(32'h00488000, ALU_SRA, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_U5, 7'h00);
        row(32'h02300000, ALU_SLT, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h027f0000, ALU_SLTU, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h02bf0000, ALU_ADD, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h03600000, ALU_AND, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_U12, 7'h00);
        row(32'h03bf0000, ALU_OR, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_U12, 7'h00);
        row(32'h03e00000, ALU_XOR, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_U12, 7'h00);
        row(32'h15234000, ALU_LUI, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h09, I_U20, 7'h00);
        row(32'h19800000, ALU_ADD, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h19, I_P20, 7'h00);
        row(32'h1cabc000, ALU_ADD, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h19, I_U20, 7'h00);
        row(32'h4e000000, ALU_ADD, MD_NONE, 1'b0, BR_JIRL, MEM_NONE, CSR_NONE, 7'h15, I_B16, 7'h00);
        row(32'h50000000, ALU_NONE, MD_NONE, 1'b0, BR_B, MEM_NONE, CSR_NONE, 7'h00, I_J26, 7'h00);
        row(32'h56000000, ALU_ADD, MD_NONE, 1'b0, BR_BL, MEM_NONE, CSR_NONE, 7'h15, I_J26, 7'h00);
        row(32'h5a000000, ALU_NONE, MD_NONE, 1'b0, BR_BEQ, MEM_NONE, CSR_NONE, 7'h02, I_B16, 7'h00);
        row(32'h5c000000, ALU_NONE, MD_NONE, 1'b0, BR_BNE, MEM_NONE, CSR_NONE, 7'h02, I_B16, 7'h00);
        row(32'h60000000, ALU_NONE, MD_NONE, 1'b0, BR_BLT, MEM_NONE, CSR_NONE, 7'h02, I_B16, 7'h00);
        row(32'h66000000, ALU_NONE, MD_NONE, 1'b0, BR_BGE, MEM_NONE, CSR_NONE, 7'h02, I_B16, 7'h00);
        row(32'h68000000, ALU_NONE, MD_NONE, 1'b0, BR_BLTU, MEM_NONE, CSR_NONE, 7'h02, I_B16, 7'h00);
        row(32'h6c000000, ALU_NONE, MD_NONE, 1'b0, BR_BGEU, MEM_NONE, CSR_NONE, 7'h02, I_B16, 7'h00);
        row(32'h28200000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_LD_B, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h28600000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_LD_H, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h28800000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_LD_W, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h2a000000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_LD_BU, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h2a400000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_LD_HU, CSR_NONE, 7'h09, I_S12, 7'h00);
        row(32'h29200000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_ST_B, CSR_NONE, 7'h0a, I_S12, 7'h00);
        row(32'h29600000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_ST_H, CSR_NONE, 7'h0a, I_S12, 7'h00);
        row(32'h29800000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_ST_W, CSR_NONE, 7'h0a, I_S12, 7'h00);
        row(32'h001c0000, ALU_NONE, MD_MUL, 1'b1, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h001c8000, ALU_NONE, MD_MULH, 1'b1, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h001d0000, ALU_NONE, MD_MULH, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00200000, ALU_NONE, MD_DIV, 1'b1, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00208000, ALU_NONE, MD_MOD, 1'b1, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00210000, ALU_NONE, MD_DIV, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h00218000, ALU_NONE, MD_MOD, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        row(32'h002a0000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h08);
        row(32'h002b0000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h00, I_NO, 7'h04);
        // dropped barrier and timer encodings and an all-ones word
        row(32'h38720000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h10);
        // rdcntvl.w needs rj and rk fixed
        cur_mask = 3'b100;
        row(32'h00006000, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h10);
        cur_mask = 3'b111;
        row(32'hffffffff, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h10);
        // side inputs {plv, has_int, adef}
        cur_side = 4'b1100;
        row(32'h00150000, ALU_OR, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h00);
        cur_side = 4'b0011;
        row(32'h00170000, ALU_SLL, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h41);
        // csr group keeps rj fixed
        cur_mask = 3'b101;
        cur_side = 4'b0000;
        row(32'h04001400, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_RD, 7'h01, I_NO, 7'h00);
        row(32'h04001420, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_WR, 7'h43, I_NO, 7'h00);
        row(32'h040014a0, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_XCHG, 7'h63, I_NO, 7'h00);
        cur_side = 4'b1100;
        row(32'h04001400, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_RD, 7'h01, I_NO, 7'h20);
        row(32'h04001420, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_WR, 7'h43, I_NO, 7'h20);
        row(32'h040014a0, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_XCHG, 7'h63, I_NO, 7'h20);
        // plv 2 is still allowed to touch csrs
        cur_side = 4'b1000;
        row(32'h04001420, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_WR, 7'h43, I_NO, 7'h00);
        // ertn keeps every field fixed
        cur_mask = 3'b000;
        cur_side = 4'b0000;
        row(32'h06483800, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h02);
        cur_side = 4'b1100;
        row(32'h06483800, ALU_NONE, MD_NONE, 1'b0, BR_NONE, MEM_NONE, CSR_NONE, 7'h01, I_NO, 7'h22);

        // 16 reset cycles with a decodable word held on the inputs
        for (int n = 0; n < 16; n++) begin
            // no valid strobe on the last edge before release
            if (n == 15) in_valid = 1'b0;
            @(negedge clk);
        end
        check_valid(out_valid, 1'b0);
        check_ctrl(ctrl, '0);
        check_imm(imm, 32'b0);
        check_excp(excp, '0);
        arst_n = 1'b1;

        foreach (tbl[i]) begin
            e = tbl[i];
            lcg_state = lcg_next(lcg_state);
            r = lcg_state;
            w = e.tmpl;
            if (e.rmask[2]) w[4:0] = r[20:16];
            if (e.rmask[1]) w[9:5] = r[25:21];
            if (e.rmask[0]) w[14:10] = r[30:26];

            exp_ctrl = '0;
            exp_ctrl.alu_op = e.alu;
            exp_ctrl.md_op = e.md;
            exp_ctrl.md_signed = e.sgn;
            exp_ctrl.br_op = e.br;
            exp_ctrl.mem_op = e.mem;
            exp_ctrl.csr_op = e.csr;
            exp_ctrl.csr_addr = w[23:10];
            {exp_ctrl.csr_we, exp_ctrl.csr_wdata_sel, exp_ctrl.src1_is_pc,
             exp_ctrl.src2_is_imm, exp_ctrl.src2_is_4, exp_ctrl.src_reg_is_rd,
             exp_ctrl.reg_we} = e.flags;
            exp_ctrl.dest = (e.br == BR_BL) ? 5'd1 : w[4:0];
            exp_ctrl.regs = '{w[4:0], w[9:5], w[14:10]};
            exp_imm = expect_imm(e.fmt, w);

            in_valid = 1'b1;
            inst = w;
            {csr_plv, csr_has_int, excp_adef} = e.side;
            @(negedge clk);
            check_valid(out_valid, 1'b1);
            check_ctrl(ctrl, exp_ctrl);
            check_imm(imm, exp_imm);
            check_excp(excp, e.ex);

            // occasional idle cycle with a junk word on the bus
            if (r[3:0] < 4'd5) begin
                in_valid = 1'b0;
                inst = ~w;
                csr_plv = 2'd3;
                csr_has_int = 1'b1;
                excp_adef = 1'b1;
                @(negedge clk);
                check_valid(out_valid, 1'b0);
                check_ctrl(ctrl, exp_ctrl);
                check_imm(imm, exp_imm);
                check_excp(excp, e.ex);
            end
        end

        in_valid = 1'b0;
        @(negedge clk);
        check_valid(out_valid, 1'b0);

        $display("errors: ctrl=%0d imm=%0d excp=%0d valid=%0d",
                 ctrl_errs, imm_errs, excp_errs, valid_errs);
        if (ctrl_errs + imm_errs + excp_errs + valid_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: include/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// word and field widths
`define INST_W       32
`define REG_IDX_W    5
`define CSR_ADDR_W   14

// opcode field widths, msb first
`define OP_HI_W      6
`define OP_MID_W     4
`define OP_SUB_W     2
`define OP_LO_W      5

// field positions inside the instruction word
`define OP_HI_LSB    26
`define OP_MID_LSB   22
`define OP_SUB_LSB   20
`define OP_LO_LSB    15
`define RD_LSB       0
`define RJ_LSB       5
`define RK_LSB       10
`define IMM_LSB      10
`define I20_LSB      5

// architectural constants
`define LINK_REG     5'd1
`define PLV_USER     2'd3

// major opcodes in inst[31:26]
`define MAJ_ALU       6'h00
`define MAJ_CSR       6'h01
`define MAJ_LU12I     6'h05
`define MAJ_PCADDI    6'h06
`define MAJ_PCADDU12I 6'h07
`define MAJ_MEM       6'h0a
`define MAJ_JIRL      6'h13
`define MAJ_B         6'h14
`define MAJ_BL        6'h15
`define MAJ_BEQ       6'h16
`define MAJ_BNE       6'h17
`define MAJ_BLT       6'h18
`define MAJ_BGE       6'h19
`define MAJ_BLTU      6'h1a
`define MAJ_BGEU      6'h1b

`endif

// File: inst_decode_stage.f
+incdir+include
verilog/decode_pkg.sv
verilog/op_classify.sv
verilog/ctrl_gen.sv
verilog/imm_gen.sv
verilog/id_output_stage.sv
verilog/inst_decode_stage.sv
dv/inst_decode_stage_chk.sv
dv/inst_decode_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f inst_decode_stage.f \
    --top-module inst_decode_stage_tb \
    -o sim_decode

sim_out=$(./obj_dir/sim_decode)
echo "$sim_out"
echo "$sim_out" | grep -q "TESTBENCH PASSED"

// File: verilog/ctrl_gen.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module ctrl_gen (
    input  decode_pkg::op_e          op,
    input  logic [`INST_W-1:0]       inst,
    output decode_pkg::decode_ctrl_t ctrl
);
    import decode_pkg::*;

    always_comb begin
        ctrl.regs.rd = inst[`RD_LSB +: `REG_IDX_W];
        ctrl.regs.rj = inst[`RJ_LSB +: `REG_IDX_W];
        ctrl.regs.rk = inst[`RK_LSB +: `REG_IDX_W];
        ctrl.csr_addr = inst[`IMM_LSB +: `CSR_ADDR_W];

        // link address is pc + 4 through the adder
        case (op)
            OP_ADD_W, OP_ADDI_W, OP_JIRL, OP_BL,
            OP_PCADDI, OP_PCADDU12I:   ctrl.alu_op = ALU_ADD;
            OP_SUB_W:                  ctrl.alu_op = ALU_SUB;
            OP_SLT, OP_SLTI:           ctrl.alu_op = ALU_SLT;
            OP_SLTU, OP_SLTUI:         ctrl.alu_op = ALU_SLTU;
            OP_AND, OP_ANDI:           ctrl.alu_op = ALU_AND;
            OP_NOR:                    ctrl.alu_op = ALU_NOR;
            OP_OR, OP_ORI:             ctrl.alu_op = ALU_OR;
            OP_XOR, OP_XORI:           ctrl.alu_op = ALU_XOR;
            OP_SLL_W, OP_SLLI_W:       ctrl.alu_op = ALU_SLL;
            OP_SRL_W, OP_SRLI_W:       ctrl.alu_op = ALU_SRL;
            OP_SRA_W, OP_SRAI_W:       ctrl.alu_op = ALU_SRA;
            OP_LU12I_W:                ctrl.alu_op = ALU_LUI;
            default:                   ctrl.alu_op = ALU_NONE;
        endcase

        case (op)
            OP_MUL_W:                  ctrl.md_op = MD_MUL;
            OP_MULH_W, OP_MULH_WU:     ctrl.md_op = MD_MULH;
            OP_DIV_W, OP_DIV_WU:       ctrl.md_op = MD_DIV;
            OP_MOD_W, OP_MOD_WU:       ctrl.md_op = MD_MOD;
            default:                   ctrl.md_op = MD_NONE;
        endcase
        ctrl.md_signed = op inside {OP_MUL_W, OP_MULH_W, OP_DIV_W, OP_MOD_W};

        case (op)
            OP_BEQ:  ctrl.br_op = BR_BEQ;
            OP_BNE:  ctrl.br_op = BR_BNE;
            OP_BLT:  ctrl.br_op = BR_BLT;
            OP_BGE:  ctrl.br_op = BR_BGE;
            OP_BLTU: ctrl.br_op = BR_BLTU;
            OP_BGEU: ctrl.br_op = BR_BGEU;
            OP_JIRL: ctrl.br_op = BR_JIRL;
            OP_BL:   ctrl.br_op = BR_BL;
            OP_B:    ctrl.br_op = BR_B;
            default: ctrl.br_op = BR_NONE;
        endcase

        case (op)
            OP_LD_B:  ctrl.mem_op = MEM_LD_B;
            OP_LD_H:  ctrl.mem_op = MEM_LD_H;
            OP_LD_W:  ctrl.mem_op = MEM_LD_W;
            OP_LD_BU: ctrl.mem_op = MEM_LD_BU;
            OP_LD_HU: ctrl.mem_op = MEM_LD_HU;
            OP_ST_B:  ctrl.mem_op = MEM_ST_B;
            OP_ST_H:  ctrl.mem_op = MEM_ST_H;
            OP_ST_W:  ctrl.mem_op = MEM_ST_W;
            default:  ctrl.mem_op = MEM_NONE;
        endcase

        case (op)
            OP_CSRRD:   ctrl.csr_op = CSR_RD;
            OP_CSRWR:   ctrl.csr_op = CSR_WR;
            OP_CSRXCHG: ctrl.csr_op = CSR_XCHG;
            default:    ctrl.csr_op = CSR_NONE;
        endcase
        ctrl.csr_we        = op inside {OP_CSRWR, OP_CSRXCHG};
        ctrl.csr_wdata_sel = (op == OP_CSRXCHG);

        // operand routing
        ctrl.src1_is_pc  = op inside {OP_JIRL, OP_BL, OP_PCADDI, OP_PCADDU12I};
        ctrl.src2_is_4   = op inside {OP_JIRL, OP_BL};
        ctrl.src2_is_imm = op inside {OP_SLLI_W, OP_SRLI_W, OP_SRAI_W, OP_ADDI_W,
                                      OP_SLTI, OP_SLTUI, OP_ANDI, OP_ORI, OP_XORI,
                                      OP_PCADDI, OP_PCADDU12I, OP_LU12I_W,
                                      OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
                                      OP_ST_B, OP_ST_H, OP_ST_W};
        // rd is read as a source by compares, stores and csr writes
        ctrl.src_reg_is_rd = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                                        OP_ST_B, OP_ST_H, OP_ST_W, OP_CSRWR, OP_CSRXCHG};

        ctrl.reg_we = !(op inside {OP_ST_B, OP_ST_H, OP_ST_W,
                                   OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                                   OP_B, OP_SYSCALL});
        ctrl.dest = (op == OP_BL) ? `LINK_REG : inst[`RD_LSB +: `REG_IDX_W];
    end

endmodule

// File: verilog/decode_pkg.sv
`include "decode_defs.svh"

package decode_pkg;

    // one value per decoded instruction
    typedef enum logic [5:0] {
        OP_INVALID,
        OP_ADD_W, OP_SUB_W, OP_SLT, OP_SLTU,
        OP_NOR, OP_AND, OP_OR, OP_XOR,
        OP_SLL_W, OP_SRL_W, OP_SRA_W,
        OP_MUL_W, OP_MULH_W, OP_MULH_WU,
        OP_DIV_W, OP_MOD_W, OP_DIV_WU, OP_MOD_WU,
        OP_BREAK, OP_SYSCALL,
        OP_SLLI_W, OP_SRLI_W, OP_SRAI_W,
        OP_SLTI, OP_SLTUI, OP_ADDI_W,
        OP_ANDI, OP_ORI, OP_XORI,
        OP_LD_B, OP_LD_H, OP_LD_W,
        OP_ST_B, OP_ST_H, OP_ST_W,
        OP_LD_BU, OP_LD_HU,
        OP_JIRL, OP_B, OP_BL,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LU12I_W, OP_PCADDI, OP_PCADDU12I,
        OP_CSRRD, OP_CSRWR, OP_CSRXCHG, OP_ERTN
    } op_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        MD_NONE, MD_MUL, MD_MULH, MD_DIV, MD_MOD
    } md_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JIRL, BR_BL, BR_B
    } br_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LD_B, MEM_LD_H, MEM_LD_W, MEM_LD_BU,
        MEM_LD_HU, MEM_ST_B, MEM_ST_H, MEM_ST_W
    } mem_op_e;

    typedef enum logic [1:0] {
        CSR_NONE, CSR_RD, CSR_WR, CSR_XCHG
    } csr_op_e;

    typedef struct packed {
        logic [`REG_IDX_W-1:0] rd;
        logic [`REG_IDX_W-1:0] rj;
        logic [`REG_IDX_W-1:0] rk;
    } reg_fields_t;

    typedef struct packed {
        alu_op_e                alu_op;
        md_op_e                 md_op;
        logic                   md_signed;
        br_op_e                 br_op;
        mem_op_e                mem_op;
        csr_op_e                csr_op;
        logic [`CSR_ADDR_W-1:0] csr_addr;
        logic                   csr_we;
        // 1 selects the rj mask path of csrxchg
        logic                   csr_wdata_sel;
        logic                   src1_is_pc;
        logic                   src2_is_imm;
        logic                   src2_is_4;
        logic                   src_reg_is_rd;
        logic                   reg_we;
        logic [`REG_IDX_W-1:0]  dest;
        reg_fields_t            regs;
    } decode_ctrl_t;

    typedef struct packed {
        logic adef;
        logic ipe;
        logic ine;
        logic brk;
        logic sys;
        logic ertn;
        logic intr;
    } excp_t;

endpackage

// File: verilog/id_output_stage.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module id_output_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic                     csr_has_int,
    input  logic                     excp_adef,
    input  logic [1:0]               csr_plv,
    input  decode_pkg::op_e          op,
    input  decode_pkg::decode_ctrl_t ctrl_d,
    input  logic [`INST_W-1:0]       imm_d,
    output logic                     out_valid,
    output decode_pkg::decode_ctrl_t ctrl,
    output logic [`INST_W-1:0]       imm,
    output decode_pkg::excp_t        excp
);
    import decode_pkg::*;

    logic  kernel_inst;
    excp_t excp_d;

    assign kernel_inst = op inside {OP_CSRRD, OP_CSRWR, OP_CSRXCHG, OP_ERTN};

    always_comb begin
        excp_d.adef = excp_adef;
        // kernel-only instructions trap in user mode
        excp_d.ipe  = kernel_inst && (csr_plv == `PLV_USER);
        excp_d.ine  = (op == OP_INVALID);
        excp_d.brk  = (op == OP_BREAK);
        excp_d.sys  = (op == OP_SYSCALL);
        excp_d.ertn = (op == OP_ERTN);
        excp_d.intr = csr_has_int;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload only moves on a new instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl <= '0;
            imm  <= '0;
            excp <= '0;
        end else if (in_valid) begin
            ctrl <= ctrl_d;
            imm  <= imm_d;
            excp <= excp_d;
        end
    end

endmodule

// File: verilog/imm_gen.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module imm_gen (
    input  decode_pkg::op_e    op,
    input  logic [`INST_W-1:0] inst,
    output logic [`INST_W-1:0] imm
);
    import decode_pkg::*;

    logic [4:0]  ui5;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;

    assign ui5 = inst[`RK_LSB +: 5];
    assign i12 = inst[`IMM_LSB +: 12];
    assign i16 = inst[`IMM_LSB +: 16];
    assign i20 = inst[`I20_LSB +: 20];
    // offs26 is split, the low field sits above the high one
    assign i26 = {inst[9:0], inst[`IMM_LSB +: 16]};

    always_comb begin
        case (op)
            OP_SLLI_W, OP_SRLI_W, OP_SRAI_W:
                imm = {27'b0, ui5};
            OP_ADDI_W, OP_SLTI, OP_SLTUI,
            OP_LD_B, OP_LD_H, OP_LD_W, OP_LD_BU, OP_LD_HU,
            OP_ST_B, OP_ST_H, OP_ST_W:
                imm = {{20{i12[11]}}, i12};
            OP_ANDI, OP_ORI, OP_XORI:
                imm = {20'b0, i12};
            OP_JIRL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                imm = {{14{i16[15]}}, i16, 2'b0};
            OP_LU12I_W, OP_PCADDU12I:
                imm = {i20, 12'b0};
            OP_PCADDI:
                imm = {{10{i20[19]}}, i20, 2'b0};
            OP_B, OP_BL:
                imm = {{4{i26[25]}}, i26, 2'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// File: verilog/inst_decode_stage.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module inst_decode_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     in_valid,
    input  logic [`INST_W-1:0]       inst,
    input  logic [1:0]               csr_plv,
    input  logic                     csr_has_int,
    input  logic                     excp_adef,
    output logic                     out_valid,
    output decode_pkg::decode_ctrl_t ctrl,
    output logic [`INST_W-1:0]       imm,
    output decode_pkg::excp_t        excp
);
    import decode_pkg::*;

    op_e                op;
    decode_ctrl_t       ctrl_d;
    logic [`INST_W-1:0] imm_d;

    op_classify u_op_classify (
        .inst (inst),
        .op   (op)
    );

    // control and immediate are built in parallel from the same opcode
    ctrl_gen u_ctrl_gen (
        .op   (op),
        .inst (inst),
        .ctrl (ctrl_d)
    );

    imm_gen u_imm_gen (
        .op   (op),
        .inst (inst),
        .imm  (imm_d)
    );

    id_output_stage u_id_output_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .csr_has_int (csr_has_int),
        .excp_adef   (excp_adef),
        .csr_plv     (csr_plv),
        .op          (op),
        .ctrl_d      (ctrl_d),
        .imm_d       (imm_d),
        .out_valid   (out_valid),
        .ctrl        (ctrl),
        .imm         (imm),
        .excp        (excp)
    );

endmodule

// File: verilog/op_classify.sv
`timescale 1ns/1ns
`include "decode_defs.svh"

module op_classify (
    input  logic [`INST_W-1:0] inst,
    output decode_pkg::op_e    op
);
    import decode_pkg::*;

    logic [`OP_HI_W-1:0]   op_hi;
    logic [`OP_MID_W-1:0]  op_mid;
    logic [`OP_SUB_W-1:0]  op_sub;
    logic [`OP_LO_W-1:0]   op_lo;
    logic [`REG_IDX_W-1:0] rd;
    logic [`REG_IDX_W-1:0] rj;
    logic [`REG_IDX_W-1:0] rk;

    assign op_hi  = inst[`OP_HI_LSB  +: `OP_HI_W];
    assign op_mid = inst[`OP_MID_LSB +: `OP_MID_W];
    assign op_sub = inst[`OP_SUB_LSB +: `OP_SUB_W];
    assign op_lo  = inst[`OP_LO_LSB  +: `OP_LO_W];
    assign rd     = inst[`RD_LSB +: `REG_IDX_W];
    assign rj     = inst[`RJ_LSB +: `REG_IDX_W];
    assign rk     = inst[`RK_LSB +: `REG_IDX_W];

    always_comb begin
        op = OP_INVALID;
        case (op_hi)
            `MAJ_ALU: begin
                if (op_mid == 4'h0 && op_sub == 2'h1) begin
                    // three-register ops
                    case (op_lo)
                        5'h00:   op = OP_ADD_W;
                        5'h02:   op = OP_SUB_W;
                        5'h04:   op = OP_SLT;
                        5'h05:   op = OP_SLTU;
                        5'h08:   op = OP_NOR;
                        5'h09:   op = OP_AND;
                        5'h0a:   op = OP_OR;
                        5'h0b:   op = OP_XOR;
                        5'h0e:   op = OP_SLL_W;
                        5'h0f:   op = OP_SRL_W;
                        5'h10:   op = OP_SRA_W;
                        5'h18:   op = OP_MUL_W;
                        5'h19:   op = OP_MULH_W;
                        5'h1a:   op = OP_MULH_WU;
                        default: op = OP_INVALID;
                    endcase
                end else if (op_mid == 4'h0 && op_sub == 2'h2) begin
                    // divide group shares the slot with break and syscall
                    case (op_lo)
                        5'h00:   op = OP_DIV_W;
                        5'h01:   op = OP_MOD_W;
                        5'h02:   op = OP_DIV_WU;
                        5'h03:   op = OP_MOD_WU;
                        5'h14:   op = OP_BREAK;
                        5'h16:   op = OP_SYSCALL;
                        default: op = OP_INVALID;
                    endcase
                end else if (op_mid == 4'h1 && op_sub == 2'h0) begin
                    case (op_lo)
                        5'h01:   op = OP_SLLI_W;
                        5'h09:   op = OP_SRLI_W;
                        5'h11:   op = OP_SRAI_W;
                        default: op = OP_INVALID;
                    endcase
                end else begin
                    // 12-bit immediate forms, op_sub belongs to the immediate
                    case (op_mid)
                        4'h8:    op = OP_SLTI;
                        4'h9:    op = OP_SLTUI;
                        4'ha:    op = OP_ADDI_W;
                        4'hd:    op = OP_ANDI;
                        4'he:    op = OP_ORI;
                        4'hf:    op = OP_XORI;
                        default: op = OP_INVALID;
                    endcase
                end
            end
            `MAJ_CSR: begin
                if (op_mid[3:2] == 2'b00) begin
                    // rj picks the csr access kind
                    if (rj == 5'd0) begin
                        op = OP_CSRRD;
                    end else if (rj == 5'd1) begin
                        op = OP_CSRWR;
                    end else begin
                        op = OP_CSRXCHG;
                    end
                end else if (op_mid == 4'h9 && op_sub == 2'h0 && op_lo == 5'h10 &&
                             rk == 5'h0e && rj == 5'd0 && rd == 5'd0) begin
                    op = OP_ERTN;
                end
            end
            `MAJ_LU12I:     op = op_mid[3] ? OP_INVALID : OP_LU12I_W;
            `MAJ_PCADDI:    op = op_mid[3] ? OP_INVALID : OP_PCADDI;
            `MAJ_PCADDU12I: op = op_mid[3] ? OP_INVALID : OP_PCADDU12I;
            `MAJ_MEM: begin
                case (op_mid)
                    4'h0:    op = OP_LD_B;
                    4'h1:    op = OP_LD_H;
                    4'h2:    op = OP_LD_W;
                    4'h4:    op = OP_ST_B;
                    4'h5:    op = OP_ST_H;
                    4'h6:    op = OP_ST_W;
                    4'h8:    op = OP_LD_BU;
                    4'h9:    op = OP_LD_HU;
                    default: op = OP_INVALID;
                endcase
            end
            `MAJ_JIRL: op = OP_JIRL;
            `MAJ_B:    op = OP_B;
            `MAJ_BL:   op = OP_BL;
            `MAJ_BEQ:  op = OP_BEQ;
            `MAJ_BNE:  op = OP_BNE;
            `MAJ_BLT:  op = OP_BLT;
            `MAJ_BGE:  op = OP_BGE;
            `MAJ_BLTU: op = OP_BLTU;
            `MAJ_BGEU: op = OP_BGEU;
            default:   op = OP_INVALID;
        endcase
    end

endmodule
